/* design/acq_top.sv */
module acq_top #(
	parameter int CMD_DEPTH = 4,
	parameter int SAMPLE_DEPTH = 16
) (
	input  logic           clk,
	input  logic           rst,
	input  logic [15:0]    data_in,
	output logic [15:0]    data_out,
	input  ebi_pkg::addr_t addr,
	input  logic           rd,
	input  logic           wr,
	input  logic           cs,
	output logic           irq
);

	import ebi_pkg::*;

	// Command path
	cmd_word_t cmd_word;
	cmd_word_t cmd_head;
	logic cmd_push;
	logic cmd_pop;
	fifo_flags_t cmd_flags;

	// Job link
	logic job_req;
	logic job_ack;
	gen_job_t job;

	// Sample path
	logic sample_push;
	logic sample_pop;
	logic [15:0] sample_data;
	logic [15:0] sample_head;
	fifo_flags_t sample_flags;

	sync_fifo #(
		.WIDTH($bits(cmd_word_t)),
		.DEPTH(CMD_DEPTH)
	) cmd_fifo0 (
		.clk(clk),
		.rst(rst),
		.push(cmd_push),
		.wdata(cmd_word),
		.pop(cmd_pop),
		.rdata(cmd_head),
		.flags(cmd_flags)
	);

	cmd_executor exec0 (
		.clk(clk),
		.rst(rst),
		.cmd_empty(cmd_flags.empty),
		.cmd_head(cmd_head),
		.cmd_pop(cmd_pop),
		.job_req(job_req),
		.job(job),
		.job_ack(job_ack)
	);

	sample_gen gen0 (
		.clk(clk),
		.rst(rst),
		.job_req(job_req),
		.job(job),
		.job_ack(job_ack),
		.sample_push(sample_push),
		.sample_data(sample_data),
		.sample_full(sample_flags.full)
	);

	sync_fifo #(
		.WIDTH(16),
		.DEPTH(SAMPLE_DEPTH)
	) sample_fifo0 (
		.clk(clk),
		.rst(rst),
		.push(sample_push),
		.wdata(sample_data),
		.pop(sample_pop),
		.rdata(sample_head),
		.flags(sample_flags)
	);

	ebi ebi0 (
		.clk(clk),
		.rst(rst),
		.data_in(data_in),
		.data_out(data_out),
		.addr(addr),
		.rd(rd),
		.wr(wr),
		.cs(cs),
		.cmd_push(cmd_push),
		.cmd_word(cmd_word),
		.cmd_flags(cmd_flags),
		.sample_pop(sample_pop),
		.sample_head(sample_head),
		.sample_flags(sample_flags),
		.irq(irq)
	);

endmodule

/* design/cmd_executor.sv */
module cmd_executor (
	input  logic               clk,
	input  logic               rst,
	input  logic               cmd_empty,
	input  ebi_pkg::cmd_word_t cmd_head,
	output logic               cmd_pop,
	output logic               job_req,
	output ebi_pkg::gen_job_t  job,
	input  logic               job_ack
);

	import ebi_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_POP,
		ST_REQ,
		ST_RELEASE
	} exec_state_t;

	exec_state_t state;
	gen_job_t dec_job;
	logic dec_valid;

	// Same payload bits, read through the view the opcode selects
	always_comb begin
		dec_job = '0;
		dec_valid = 1'b0;
		case (cmd_head.opcode)
			OP_RAMP: begin
				dec_job.start = cmd_head.payload.ramp.start;
				dec_job.step = cmd_head.payload.ramp.step;
				dec_job.count = cmd_head.payload.ramp.count;
				dec_valid = (cmd_head.payload.ramp.count != 16'd0);
			end
			OP_CONST: begin
				dec_job.start = cmd_head.payload.cnst.value;
				dec_job.step = 16'd0;
				dec_job.count = cmd_head.payload.cnst.count;
				dec_valid = (cmd_head.payload.cnst.count != 16'd0);
			end
			default: begin
				dec_valid = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			cmd_pop <= 1'b0;
			job_req <= 1'b0;
		end else begin
			cmd_pop <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (!cmd_empty) begin
						cmd_pop <= 1'b1;
						state <= ST_POP;
					end
				end
				ST_POP: begin
					// Head is still valid while the pop is in flight
					if (dec_valid) begin
						job_req <= 1'b1;
						state <= ST_REQ;
					end else begin
						state <= ST_IDLE;
					end
				end
				ST_REQ: begin
					if (job_ack) begin
						job_req <= 1'b0;
						state <= ST_RELEASE;
					end
				end
				ST_RELEASE: begin
					// Generator holds ack until its run is over
					if (!job_ack) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_POP) begin
			job <= dec_job;
		end
	end

	assert property (@(posedge clk) disable iff (rst) job_req |=> (!job_req || $stable(job)));

endmodule

/* design/ebi.sv */
module ebi (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [15:0]          data_in,
	output logic [15:0]          data_out,
	input  ebi_pkg::addr_t       addr,
	input  logic                 rd,
	input  logic                 wr,
	input  logic                 cs,
	output logic                 cmd_push,
	output ebi_pkg::cmd_word_t   cmd_word,
	input  ebi_pkg::fifo_flags_t cmd_flags,
	output logic                 sample_pop,
	input  logic [15:0]          sample_head,
	input  ebi_pkg::fifo_flags_t sample_flags,
	output logic                 irq
);

	import ebi_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_LOAD,
		ST_OVER
	} bus_state_t;

	bus_state_t state;
	bus_state_t state_next;
	logic capture;
	logic [15:0] cap [6];
	logic cmd_overflow;
	logic rd_d;
	logic rd_start;
	logic status_read;
	status_t status_next;
	status_t status_r;
	status_t snapshot;

	// Only command word addresses are captured
	assign capture = (state == ST_FETCH) && cs && wr &&
		(addr >= ADDR_CMD_W1) && (addr <= ADDR_CMD_W6);

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: state_next = ST_FETCH;
			ST_FETCH: begin
				if (capture && addr == ADDR_CMD_W6) begin
					state_next = ST_LOAD;
				end
			end
			ST_LOAD: state_next = ST_OVER;
			ST_OVER: begin
				// Wait for the host to release the bus
				if (!wr && !rd) begin
					state_next = ST_FETCH;
				end
			end
			default: state_next = ST_IDLE;
		endcase
	end

	// A full command FIFO drops the whole command
	assign cmd_push = (state == ST_LOAD) && !cmd_flags.full;

	// Word 1 lands in the top bits, so the opcode comes first
	assign cmd_word = {cap[0], cap[1], cap[2], cap[3], cap[4], cap[5]};

	always_ff @(posedge clk) begin
		if (capture) begin
			cap[addr[2:0] - 3'd1] <= data_in;
		end
	end

	// Read strobe edge
	assign rd_start = cs && rd && !rd_d;
	assign status_read = rd_start && (addr == ADDR_STATUS);
	assign sample_pop = rd_start && (addr == ADDR_SAMPLE) && !sample_flags.empty;

	always_comb begin
		status_next = '0;
		status_next.cmd_almost_full = cmd_flags.almost_full;
		status_next.cmd_full = cmd_flags.full;
		status_next.cmd_almost_empty = cmd_flags.almost_empty;
		status_next.cmd_empty = cmd_flags.empty;
		status_next.smp_almost_full = sample_flags.almost_full;
		status_next.smp_full = sample_flags.full;
		status_next.smp_empty = sample_flags.empty;
		status_next.smp_almost_empty = sample_flags.almost_empty;
		status_next.cmd_overflow = cmd_overflow;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			rd_d <= 1'b0;
			cmd_overflow <= 1'b0;
			status_r <= '0;
			snapshot <= '0;
			irq <= 1'b0;
		end else begin
			state <= state_next;
			rd_d <= cs && rd;
			status_r <= status_next;
			irq <= (status_r != snapshot);
			if (state == ST_LOAD && cmd_flags.full) begin
				cmd_overflow <= 1'b1;
			end else if (status_read) begin
				cmd_overflow <= 1'b0;
			end
			if (status_read) begin
				snapshot <= status_r;
				// Host has seen the overflow, so it no longer counts as news
				snapshot.cmd_overflow <= 1'b0;
			end
		end
	end

	// Read data is ready one clock after the rd edge
	always_ff @(posedge clk) begin
		if (rd_start) begin
			case (addr)
				ADDR_STATUS: data_out <= status_r;
				ADDR_SAMPLE: data_out <= sample_flags.empty ? 16'h0000 : sample_head;
				default: data_out <= 16'h0000;
			endcase
		end
	end

endmodule

/* design/ebi_pkg.sv */
package ebi_pkg;

	// External bus address, 19 bits wide
	typedef logic [18:0] addr_t;

	// Bus address map
	localparam addr_t ADDR_STATUS = 19'd0;
	localparam addr_t ADDR_CMD_W1 = 19'd1;
	localparam addr_t ADDR_CMD_W2 = 19'd2;
	localparam addr_t ADDR_CMD_W3 = 19'd3;
	localparam addr_t ADDR_CMD_W4 = 19'd4;
	localparam addr_t ADDR_CMD_W5 = 19'd5;
	localparam addr_t ADDR_CMD_W6 = 19'd6;
	localparam addr_t ADDR_SAMPLE = 19'd7;

	// Command opcodes, anything else is dropped by the executor
	localparam logic [15:0] OP_RAMP  = 16'd1;
	localparam logic [15:0] OP_CONST = 16'd2;

	// Ramp view: words 2 to 4
	typedef struct packed {
		logic [15:0] start;
		logic [15:0] step;
		logic [15:0] count;
		logic [31:0] reserved;
	} ramp_payload_t;

	// Constant view: words 2 and 3
	typedef struct packed {
		logic [15:0] value;
		logic [15:0] count;
		logic [47:0] reserved;
	} const_payload_t;

	// Word 2 sits in the top 16 bits of the payload
	typedef union packed {
		ramp_payload_t  ramp;
		const_payload_t cnst;
	} cmd_payload_u;

	typedef struct packed {
		logic [15:0]  opcode;
		cmd_payload_u payload;
	} cmd_word_t;

	typedef struct packed {
		logic [15:0] start;
		logic [15:0] step;
		logic [15:0] count;
	} gen_job_t;

	typedef struct packed {
		logic almost_full;
		logic full;
		logic almost_empty;
		logic empty;
	} fifo_flags_t;

	// Sample FIFO flags keep the empty/almost_empty swap of the host map
	typedef struct packed {
		logic       cmd_almost_full;
		logic       cmd_full;
		logic       cmd_almost_empty;
		logic       cmd_empty;
		logic       smp_almost_full;
		logic       smp_full;
		logic       smp_empty;
		logic       smp_almost_empty;
		logic [6:0] zero;
		logic       cmd_overflow;
	} status_t;

endpackage

/* design/sample_gen.sv */
module sample_gen (
	input  logic              clk,
	input  logic              rst,
	input  logic              job_req,
	input  ebi_pkg::gen_job_t job,
	output logic              job_ack,
	output logic              sample_push,
	output logic [15:0]       sample_data,
	input  logic              sample_full
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_END
	} gen_state_t;

	gen_state_t state;
	logic [15:0] level;
	logic [15:0] step;
	logic [15:0] remaining;

	// One sample per cycle unless the FIFO is full
	assign sample_push = (state == ST_RUN) && !sample_full;
	assign sample_data = level;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			job_ack <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (job_req) begin
						job_ack <= 1'b1;
						state <= (job.count == 16'd0) ? ST_END : ST_RUN;
					end
				end
				ST_RUN: begin
					if (sample_push && remaining == 16'd1) begin
						state <= ST_END;
					end
				end
				ST_END: begin
					// Release ack once the request has gone away
					if (!job_req) begin
						job_ack <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && job_req) begin
			level <= job.start;
			step <= job.step;
			remaining <= job.count;
		end else if (sample_push) begin
			level <= level + step;
			remaining <= remaining - 16'd1;
		end
	end

	assert property (@(posedge clk) disable iff (rst) $rose(job_ack) |-> $past(job_req));

endmodule

/* design/sync_fifo.sv */
module sync_fifo #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 16
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 push,
	input  logic [WIDTH-1:0]     wdata,
	input  logic                 pop,
	output logic [WIDTH-1:0]     rdata,
	output ebi_pkg::fifo_flags_t flags
);

	localparam int AW = $clog2(DEPTH);
	localparam logic [AW-1:0] PTR_LAST = (AW)'(DEPTH - 1);
	localparam logic [AW:0] CNT_FULL = (AW + 1)'(DEPTH);
	localparam logic [AW:0] CNT_AFULL = (AW + 1)'(DEPTH - 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic [AW:0] count_next;

	// Head is read straight from the array
	assign rdata = mem[rd_ptr];

	always_comb begin
		count_next = count;
		if (push && !pop) begin
			count_next = count + 1'b1;
		end else if (pop && !push) begin
			count_next = count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			flags.almost_full <= 1'b0;
			flags.full <= 1'b0;
			flags.almost_empty <= 1'b1;
			flags.empty <= 1'b1;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			end
			count <= count_next;
			// Flags follow the new count in the same cycle
			flags.almost_full <= (count_next >= CNT_AFULL);
			flags.full <= (count_next == CNT_FULL);
			flags.almost_empty <= (count_next <= 1);
			flags.empty <= (count_next == '0);
		end
	end

	// Both neighbours must respect the flags
	assert property (@(posedge clk) disable iff (rst) push |-> !flags.full);
	assert property (@(posedge clk) disable iff (rst) pop |-> !flags.empty);

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the acquisition testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module tb_acq \
	--Mdir obj_dir

# The log decides the verdict
./obj_dir/Vtb_acq 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* testbench/acq_input.txt */
# C w1..w6 (hex command words) accepted-flag | D samples-to-drain | S status-hex irq-before-read
# Status bits 15..8: cmd af full ae empty, smp af full empty ae; bit 0 is cmd_overflow
S 3300 1
# Ramp 0x0010 + 3*i, six samples
C 0001 0010 0003 0006 0000 0000 1
D 6
S 3300 1
# Constant BEEF four times, then an unknown opcode and a zero-count ramp
C 0002 BEEF 0004 0000 0000 0000 1
C 0005 1111 2222 3333 0000 0000 1
C 0001 0100 0001 0000 0000 0000 1
D 4
S 3300 1
# Ramp of twenty fills the sample FIFO and stalls the generator
C 0001 0000 0001 0014 0000 0000 1
S 3C00 1
# Four commands fill the command FIFO, the fifth is dropped
C 0002 ABCD 0003 0000 0000 0000 1
C 0007 4444 0005 0000 0000 0000 1
C 0001 1000 FFFF 0005 0000 0000 1
C 0002 0055 0002 0000 0000 0000 1
C 0001 7777 0001 0004 0000 0000 0
S CC01 1
S CC00 0
D 30
S 3300 1

/* testbench/tb_acq.sv */
module tb_acq;

	import ebi_pkg::*;

	localparam int CMD_DEPTH = 4;
	localparam int SAMPLE_DEPTH = 16;
	localparam int STATUS_TRIES = 64;
	localparam int IRQ_CYCLES = 200;

	logic clk;
	logic rst;
	logic [15:0] data_in;
	logic [15:0] data_out;
	addr_t addr;
	logic rd;
	logic wr;
	logic cs;
	logic irq;

	// Samples still owed by the sample FIFO, oldest first
	logic [15:0] ref_q[$];

	acq_top #(
		.CMD_DEPTH(CMD_DEPTH),
		.SAMPLE_DEPTH(SAMPLE_DEPTH)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.data_in(data_in),
		.data_out(data_out),
		.addr(addr),
		.rd(rd),
		.wr(wr),
		.cs(cs),
		.irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	task automatic report_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first failure");
	endtask

	// Inputs change 1 unit after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_sample(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %h, got %h", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_status(input string name, input status_t expected,
		input status_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected status %h, got %h", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic check_irq(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected irq %b, got %b", name, expected, actual);
			report_failure();
		end
	endtask

	task automatic write_word(input addr_t a, input logic [15:0] d);
		next_cycle();
		cs = 1'b1;
		wr = 1'b1;
		addr = a;
		data_in = d;
		next_cycle();
		next_cycle();
		wr = 1'b0;
		cs = 1'b0;
	endtask

	// data_out is registered on the rd edge and held afterwards
	task automatic read_word(input addr_t a, output logic [15:0] d);
		next_cycle();
		cs = 1'b1;
		rd = 1'b1;
		addr = a;
		next_cycle();
		next_cycle();
		d = data_out;
		rd = 1'b0;
		cs = 1'b0;
	endtask

	task automatic read_status(output status_t st);
		logic [15:0] raw;
		read_word(ADDR_STATUS, raw);
		st = raw;
	endtask

	task automatic send_command(input cmd_word_t cmd);
		for (int i = 0; i < 6; i++) begin
			write_word(ADDR_CMD_W1 + addr_t'(i), cmd[95 - 16 * i -: 16]);
		end
	endtask

	// Ramp gives start + i*step, constant gives count copies, others give nothing
	function automatic void predict_samples(input logic [15:0] op, input logic [15:0] w2,
		input logic [15:0] w3, input logic [15:0] w4);
		int n;
		if (op == OP_RAMP) begin
			n = int'(w4);
			for (int i = 0; i < n; i++) begin
				ref_q.push_back(w2 + w3 * 16'(i));
			end
		end else if (op == OP_CONST) begin
			n = int'(w3);
			for (int i = 0; i < n; i++) begin
				ref_q.push_back(w2);
			end
		end
	endfunction

	task automatic wait_irq(input string name, input logic expected);
		int cycles;
		cycles = 0;
		while (irq !== expected && cycles < IRQ_CYCLES) begin
			next_cycle();
			cycles++;
		end
		if (irq !== expected) begin
			$display("Timeout: irq stayed away from %b for %0d cycles (%s)",
				expected, IRQ_CYCLES, name);
		end
		check_irq(name, expected, irq);
	endtask

	task automatic expect_status(input string name, input status_t expected,
		input logic irq_before);
		status_t st;
		int tries;
		wait_irq({name, " irq before read"}, irq_before);
		tries = 0;
		read_status(st);
		while (st !== expected && tries < STATUS_TRIES) begin
			read_status(st);
			tries++;
		end
		if (st !== expected) begin
			$display("Timeout: status never settled after %0d reads (%s)", STATUS_TRIES, name);
		end
		check_status(name, expected, st);
		// Snapshot now equals a stable status
		next_cycle();
		check_irq({name, " irq after read"}, 1'b0, irq);
	endtask

	task automatic wait_sample(input string name);
		status_t st;
		int tries;
		tries = 0;
		read_status(st);
		while (st.smp_empty && tries < STATUS_TRIES) begin
			read_status(st);
			tries++;
		end
		if (st.smp_empty) begin
			$display("Timeout: no sample arrived after %0d status reads (%s)",
				STATUS_TRIES, name);
			report_failure();
		end
	endtask

	task automatic drain_samples(input string name, input int count);
		logic [15:0] got;
		logic [15:0] expected;
		string sname;
		for (int i = 0; i < count; i++) begin
			sname = $sformatf("%s sample %0d", name, i);
			if (ref_q.size() == 0) begin
				$display("More samples drained than predicted (%s)", sname);
				report_failure();
			end
			expected = ref_q.pop_front();
			wait_sample(sname);
			read_word(ADDR_SAMPLE, got);
			check_sample(sname, expected, got);
		end
		// Nothing left to generate, so a read here must see an empty FIFO
		if (ref_q.size() == 0) begin
			read_word(ADDR_SAMPLE, got);
			check_sample({name, " empty read"}, 16'h0000, got);
		end
	endtask

	initial begin
		int fd;
		int line_no;
		int fields;
		int count;
		string line;
		string rest;
		string name;
		byte kind;
		logic [15:0] w1;
		logic [15:0] w2;
		logic [15:0] w3;
		logic [15:0] w4;
		logic [15:0] w5;
		logic [15:0] w6;
		logic [15:0] flag;
		cmd_word_t cmd;
		rst = 1'b1;
		data_in = 16'h0000;
		addr = ADDR_STATUS;
		rd = 1'b0;
		wr = 1'b0;
		cs = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		fd = $fopen("testbench/acq_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open stimulus file testbench/acq_input.txt");
			report_failure();
		end
		line_no = 0;
		while ($fgets(line, fd) != 0) begin
			line_no++;
			if (line.len() == 0) begin
				continue;
			end
			kind = line.getc(0);
			rest = line.substr(1, line.len() - 1);
			name = $sformatf("line %0d", line_no);
			case (kind)
				"C": begin
					fields = $sscanf(rest, "%h %h %h %h %h %h %h", w1, w2, w3, w4, w5, w6, flag);
					if (fields != 7) begin
						$display("Malformed command on %s", name);
						report_failure();
					end
					cmd = {w1, w2, w3, w4, w5, w6};
					send_command(cmd);
					// Flag 0 marks a command that the full FIFO drops
					if (flag != 16'h0000) begin
						predict_samples(w1, w2, w3, w4);
					end
				end
				"D": begin
					fields = $sscanf(rest, "%d", count);
					if (fields != 1) begin
						$display("Malformed drain count on %s", name);
						report_failure();
					end
					drain_samples(name, count);
				end
				"S": begin
					fields = $sscanf(rest, "%h %h", w1, flag);
					if (fields != 2) begin
						$display("Malformed status line on %s", name);
						report_failure();
					end
					expect_status(name, w1, flag[0]);
				end
				"#", "\n", "\r", " ": begin
				end
				default: begin
					$display("Unknown line kind on %s", name);
					report_failure();
				end
			endcase
		end
		$fclose(fd);
		if (ref_q.size() != 0) begin
			$display("%0d predicted samples were never drained", ref_q.size());
			report_failure();
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* verilog.f */
design/ebi_pkg.sv
design/sync_fifo.sv
design/ebi.sv
design/cmd_executor.sv
design/sample_gen.sv
design/acq_top.sv
testbench/tb_acq.sv
